/* source/bp_consts.svh */
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// halfword program counter width
`define BP_PC_W 11

// set index comes from the low pc bits
`define BP_SET_W 4
`define BP_SETS 16

// associativity and the width of a way index
`define BP_WAYS 4
`define BP_WAY_W 2

// stored tag: interrupt-mode bit on top of pc[10:4]
`define BP_TAG_W 8

// 2-bit saturating counter
`define BP_CNT_W 2

`endif

/* source/bp_isa_pkg.sv */
package bp_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// branch instructions seen by the execute stage
	////////////////////////////////////////////////////////////////////////////

	// BR_NONE means the execute slot holds no branch
	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_BEQ  = 4'd1,
		BR_BNE  = 4'd2,
		BR_BLT  = 4'd3,
		BR_BGE  = 4'd4,
		BR_BLTU = 4'd5,
		BR_BGEU = 4'd6,
		// compressed forms compare against zero
		BR_BEQZ = 4'd7,
		BR_BNEZ = 4'd8
	} branch_op_e;

	// compressed branches are one halfword long, the rest two
	function automatic logic is_compressed(input branch_op_e op);
		return (op == BR_BEQZ) || (op == BR_BNEZ);
	endfunction

	// real outcome from the alu flags
	// less already carries signed or unsigned meaning from the alu
	function automatic logic branch_taken(input branch_op_e op, input logic z,
		input logic less);
		logic taken;
		case (op)
			BR_BEQ, BR_BEQZ: taken = z;
			BR_BNE, BR_BNEZ: taken = !z;
			BR_BLT, BR_BLTU: taken = less;
			BR_BGE, BR_BGEU: taken = !less;
			default:         taken = 1'b0;
		endcase
		return taken;
	endfunction

endpackage

/* source/bp_table_pkg.sv */
package bp_table_pkg;

	`include "bp_consts.svh"

	////////////////////////////////////////////////////////////////////////////
	// table state
	////////////////////////////////////////////////////////////////////////////

	// msb of the counter is the taken prediction
	typedef enum logic [`BP_CNT_W-1:0] {
		CNT_SNT = 2'd0,
		CNT_WNT = 2'd1,
		CNT_WT  = 2'd2,
		CNT_ST  = 2'd3
	} sat_cnt_e;

	// payload of one entry, the valid bit lives apart so it can be reset
	typedef struct packed {
		logic [`BP_TAG_W-1:0] tag;
		logic [`BP_PC_W-1:0]  target;
		sat_cnt_e             cnt;
	} bht_entry_t;

	////////////////////////////////////////////////////////////////////////////
	// next-pc correction from execute
	////////////////////////////////////////////////////////////////////////////

	// code 1 is unused, the pc mux treats it like FIX_NONE
	typedef enum logic [1:0] {
		FIX_NONE = 2'd0,
		FIX_CNI  = 2'd2,
		FIX_PBT  = 2'd3
	} pc_fix_e;

endpackage

/* source/bht_way.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module bht_way (
	input  logic                        CLK,
	input  logic                        nrst,
	input  logic                        en,
	input  logic                        stall,
	input  logic                        isr_running,
	input  logic [`BP_PC_W-1:0]         if_pc,
	input  logic [`BP_PC_W-1:0]         id_pc,
	input  logic [`BP_PC_W-1:0]         exe_pc,
	input  logic                        alloc_we,
	input  logic [`BP_SET_W-1:0]        alloc_set,
	input  logic [`BP_TAG_W-1:0]        alloc_tag,
	input  logic [`BP_PC_W-1:0]         alloc_target,
	input  bp_table_pkg::sat_cnt_e      alloc_cnt,
	input  logic                        upd_we,
	input  logic [`BP_SET_W-1:0]        upd_set,
	input  bp_table_pkg::sat_cnt_e      upd_cnt,
	output logic                        if_hit,
	output logic                        id_hit,
	output logic                        exe_hit,
	output logic [`BP_PC_W-1:0]         if_target,
	output bp_table_pkg::sat_cnt_e      if_cnt,
	output logic [`BP_PC_W-1:0]         exe_target,
	output bp_table_pkg::sat_cnt_e      exe_cnt
);
	import bp_table_pkg::*;

	// one entry per set
	logic [`BP_SETS-1:0] valid;
	bht_entry_t          entries [`BP_SETS];

	// read ports: 0 fetch, 1 decode, 2 execute
	logic [`BP_PC_W-1:0]  port_pc  [3];
	logic [`BP_SET_W-1:0] port_set [3];
	logic [2:0]           port_hit;

	////////////////////////////////////////////////////////////////////////////
	// tag compare
	////////////////////////////////////////////////////////////////////////////

	assign port_pc[0] = if_pc;
	assign port_pc[1] = id_pc;
	assign port_pc[2] = exe_pc;

	for (genvar p = 0; p < 3; p++) begin : g_port
		assign port_set[p] = port_pc[p][`BP_SET_W-1:0];
		// tag is the mode bit followed by the pc bits above the set index
		assign port_hit[p] = valid[port_set[p]] &&
			(entries[port_set[p]].tag == {isr_running, port_pc[p][`BP_PC_W-1:`BP_SET_W]});
	end

	assign if_hit  = port_hit[0];
	assign id_hit  = port_hit[1];
	assign exe_hit = port_hit[2];

	// raw payload, the resolver masks it with the hit bit
	assign if_target  = entries[port_set[0]].target;
	assign if_cnt     = entries[port_set[0]].cnt;
	assign exe_target = entries[port_set[2]].target;
	assign exe_cnt    = entries[port_set[2]].cnt;

	////////////////////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////////////////////

	// valid bits are the only control state here
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			valid <= '0;
		end else if (en && !stall && alloc_we) begin
			valid[alloc_set] <= 1'b1;
		end
	end

	// allocation replaces the whole entry
	// an update only touches the counter and loses to a same-edge allocation
	always_ff @(posedge CLK) begin
		if (en && !stall) begin
			if (alloc_we) begin
				entries[alloc_set].tag    <= alloc_tag;
				entries[alloc_set].target <= alloc_target;
				entries[alloc_set].cnt    <= alloc_cnt;
			end else if (upd_we) begin
				entries[upd_set].cnt <= upd_cnt;
			end
		end
	end

	// an update only rewrites the entry that the execute port hits
	a_upd_hits: assert property (@(posedge CLK) disable iff (!nrst)
		upd_we |-> (exe_hit && (upd_set == port_set[2])));

endmodule

/* source/bht_alloc_ctrl.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module bht_alloc_ctrl (
	input  logic                        CLK,
	input  logic                        nrst,
	input  logic                        en,
	input  logic                        stall,
	input  logic                        isr_running,
	input  logic [`BP_PC_W-1:0]         id_pc,
	input  logic [`BP_PC_W-1:0]         id_target,
	input  logic                        id_is_jump,
	input  logic                        id_is_branch,
	input  logic [`BP_WAYS-1:0]         id_hit,
	output logic [`BP_WAYS-1:0]         alloc_we,
	output logic [`BP_SET_W-1:0]        alloc_set,
	output logic [`BP_TAG_W-1:0]        alloc_tag,
	output logic [`BP_PC_W-1:0]         alloc_target,
	output bp_table_pkg::sat_cnt_e      alloc_cnt,
	output logic                        id_jump_in_bht,
	output logic                        jump_alloc
);
	import bp_table_pkg::*;

	// next way to replace in each set
	logic [`BP_WAY_W-1:0] fifo_ptr [`BP_SETS];

	logic id_miss;
	logic alloc_req;

	////////////////////////////////////////////////////////////////////////////
	// allocation request
	////////////////////////////////////////////////////////////////////////////

	assign id_miss   = ~|id_hit;
	// only control transfers not already in the table get an entry
	assign alloc_req = (id_is_branch || id_is_jump) && id_miss;

	assign alloc_set    = id_pc[`BP_SET_W-1:0];
	assign alloc_tag    = {isr_running, id_pc[`BP_PC_W-1:`BP_SET_W]};
	assign alloc_target = id_target;
	// jumps always go, branches start just below the taken threshold
	assign alloc_cnt    = id_is_jump ? CNT_ST : CNT_WNT;

	// pointer of the set picks the victim way
	always_comb begin
		alloc_we = '0;
		if (alloc_req) begin
			alloc_we = `BP_WAYS'(1) << fifo_ptr[alloc_set];
		end
	end

	// tells the pc mux to skip the decode redirect
	assign id_jump_in_bht = id_is_jump && !id_miss;
	// new jump, fetch went the wrong way once
	assign jump_alloc     = id_is_jump && id_miss;

	////////////////////////////////////////////////////////////////////////////
	// fifo pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < `BP_SETS; s++) begin
				fifo_ptr[s] <= '0;
			end
		end else if (en && !stall && alloc_req) begin
			// wraps after the last way
			fifo_ptr[alloc_set] <= fifo_ptr[alloc_set] + 1'b1;
		end
	end

	// the decode pc sits in one way at most
	a_id_onehot: assert property (@(posedge CLK) disable iff (!nrst)
		$onehot0(id_hit));

endmodule

/* source/bht_resolve.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module bht_resolve (
	input  logic                        CLK,
	input  logic                        nrst,
	input  logic                        en,
	input  logic                        stall,
	input  logic [`BP_PC_W-1:0]         exe_pc,
	input  bp_isa_pkg::branch_op_e      exe_op,
	input  logic                        exe_z,
	input  logic                        exe_less,
	input  logic [`BP_WAYS-1:0]         if_hit,
	input  logic [`BP_PC_W-1:0]         if_target [`BP_WAYS],
	input  bp_table_pkg::sat_cnt_e      if_cnt [`BP_WAYS],
	input  logic [`BP_WAYS-1:0]         exe_hit,
	input  logic [`BP_PC_W-1:0]         exe_target [`BP_WAYS],
	input  bp_table_pkg::sat_cnt_e      exe_cnt [`BP_WAYS],
	input  logic                        jump_alloc,
	output logic                        if_prediction,
	output logic [`BP_PC_W-1:0]         if_pbt,
	output bp_table_pkg::pc_fix_e       exe_correction,
	output logic [`BP_PC_W-1:0]         exe_pbt,
	output logic [`BP_PC_W-1:0]         exe_cni,
	output logic [`BP_WAYS-1:0]         upd_we,
	output logic [`BP_SET_W-1:0]        upd_set,
	output bp_table_pkg::sat_cnt_e      upd_cnt,
	output logic                        flush
);
	import bp_isa_pkg::*;
	import bp_table_pkg::*;

	// merged entries, zero on a miss
	logic [`BP_PC_W-1:0]  if_tgt_m;
	logic [`BP_CNT_W-1:0] if_cnt_m;
	logic [`BP_PC_W-1:0]  exe_tgt_m;
	logic [`BP_CNT_W-1:0] exe_cnt_raw;
	sat_cnt_e             exe_cnt_m;

	logic                           exe_is_br;
	logic                           exe_taken;
	logic                           mispredict;
	logic [`BP_PC_W-`BP_SET_W-1:0]  exe_tag_pc;
	logic [`BP_PC_W-1:0]            cni_step;
	sat_cnt_e                       cnt_next;

	logic flush_q;
	logic flush_d;

	////////////////////////////////////////////////////////////////////////////
	// hit merging
	////////////////////////////////////////////////////////////////////////////

	// and-or mux, at most one way hits per port
	always_comb begin
		if_tgt_m    = '0;
		if_cnt_m    = '0;
		exe_tgt_m   = '0;
		exe_cnt_raw = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (if_hit[w]) begin
				if_tgt_m = if_tgt_m | if_target[w];
				if_cnt_m = if_cnt_m | if_cnt[w];
			end
			if (exe_hit[w]) begin
				exe_tgt_m   = exe_tgt_m | exe_target[w];
				exe_cnt_raw = exe_cnt_raw | exe_cnt[w];
			end
		end
	end

	assign exe_cnt_m = sat_cnt_e'(exe_cnt_raw);

	// fetch prediction is the counter msb
	assign if_prediction = if_cnt_m[`BP_CNT_W-1];
	assign if_pbt        = if_tgt_m;

	////////////////////////////////////////////////////////////////////////////
	// execute resolution
	////////////////////////////////////////////////////////////////////////////

	assign exe_is_br  = (exe_op != BR_NONE);
	assign exe_taken  = branch_taken(exe_op, exe_z, exe_less);
	// a missing entry counts as predicted not taken
	assign mispredict = exe_is_br && (exe_cnt_m[`BP_CNT_W-1] != exe_taken);

	always_comb begin
		exe_correction = FIX_NONE;
		if (mispredict) begin
			exe_correction = exe_taken ? FIX_PBT : FIX_CNI;
		end
	end

	assign exe_pbt = exe_tgt_m;

	// stored tag equals the exe pc bits on a hit and reads as zero on a miss
	assign exe_tag_pc = (|exe_hit) ? exe_pc[`BP_PC_W-1:`BP_SET_W] : '0;
	assign cni_step   = is_compressed(exe_op) ? `BP_PC_W'(1) : `BP_PC_W'(2);
	assign exe_cni    = {exe_tag_pc, exe_pc[`BP_SET_W-1:0]} + cni_step;

	// saturating counter step
	always_comb begin
		cnt_next = exe_cnt_m;
		if (exe_taken) begin
			if (exe_cnt_m != CNT_ST) begin
				cnt_next = sat_cnt_e'(exe_cnt_m + 1'b1);
			end
		end else if (exe_cnt_m != CNT_SNT) begin
			cnt_next = sat_cnt_e'(exe_cnt_m - 1'b1);
		end
	end

	// write back only into the hitting way and only on a change
	assign upd_we  = (exe_is_br && (cnt_next != exe_cnt_m)) ? exe_hit : '0;
	assign upd_set = exe_pc[`BP_SET_W-1:0];
	assign upd_cnt = cnt_next;

	////////////////////////////////////////////////////////////////////////////
	// flush sequencing
	////////////////////////////////////////////////////////////////////////////

	// the second flush cycle wins over anything new in that cycle
	always_comb begin
		if (flush_q) begin
			flush   = 1'b1;
			flush_d = 1'b0;
		end else if (mispredict) begin
			flush   = 1'b1;
			flush_d = 1'b1;
		end else begin
			flush   = 1'b0;
			// a new jump only flushes the following cycle
			flush_d = jump_alloc;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			flush_q <= 1'b0;
		end else if (en && !stall) begin
			flush_q <= flush_d;
		end
	end

	// ways never hold two copies of the same pc
	a_exe_onehot: assert property (@(posedge CLK) disable iff (!nrst)
		$onehot0(exe_hit));

endmodule

/* source/branch_predictor.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module branch_predictor (
	input  logic                        CLK,
	input  logic                        nrst,
	input  logic                        en,
	input  logic                        stall,
	input  logic                        isr_running,
	input  logic [`BP_PC_W-1:0]         if_pc,
	input  logic [`BP_PC_W-1:0]         id_pc,
	input  logic [`BP_PC_W-1:0]         id_target,
	input  logic                        id_is_jump,
	input  logic                        id_is_branch,
	input  logic [`BP_PC_W-1:0]         exe_pc,
	input  bp_isa_pkg::branch_op_e      exe_op,
	input  logic                        exe_z,
	input  logic                        exe_less,
	output logic                        if_prediction,
	output logic [`BP_PC_W-1:0]         if_pbt,
	output bp_table_pkg::pc_fix_e       exe_correction,
	output logic [`BP_PC_W-1:0]         exe_pbt,
	output logic [`BP_PC_W-1:0]         exe_cni,
	output logic                        flush,
	output logic                        id_jump_in_bht
);
	import bp_table_pkg::*;

	// per-way read results
	logic [`BP_WAYS-1:0] if_hit;
	logic [`BP_WAYS-1:0] id_hit;
	logic [`BP_WAYS-1:0] exe_hit;
	logic [`BP_PC_W-1:0] if_target  [`BP_WAYS];
	sat_cnt_e            if_cnt     [`BP_WAYS];
	logic [`BP_PC_W-1:0] exe_target [`BP_WAYS];
	sat_cnt_e            exe_cnt    [`BP_WAYS];

	// shared write buses
	logic [`BP_WAYS-1:0]  alloc_we;
	logic [`BP_SET_W-1:0] alloc_set;
	logic [`BP_TAG_W-1:0] alloc_tag;
	logic [`BP_PC_W-1:0]  alloc_target;
	sat_cnt_e             alloc_cnt;
	logic [`BP_WAYS-1:0]  upd_we;
	logic [`BP_SET_W-1:0] upd_set;
	sat_cnt_e             upd_cnt;
	logic                 jump_alloc;

	bht_alloc_ctrl u_alloc (
		.CLK, .nrst, .en, .stall, .isr_running,
		.id_pc, .id_target, .id_is_jump, .id_is_branch, .id_hit,
		.alloc_we, .alloc_set, .alloc_tag, .alloc_target, .alloc_cnt,
		.id_jump_in_bht, .jump_alloc
	);

	for (genvar i = 0; i < `BP_WAYS; i++) begin : g_way
		bht_way u_way (
			.CLK, .nrst, .en, .stall, .isr_running,
			.if_pc, .id_pc, .exe_pc,
			.alloc_we(alloc_we[i]), .alloc_set, .alloc_tag, .alloc_target, .alloc_cnt,
			.upd_we(upd_we[i]), .upd_set, .upd_cnt,
			.if_hit(if_hit[i]), .id_hit(id_hit[i]), .exe_hit(exe_hit[i]),
			.if_target(if_target[i]), .if_cnt(if_cnt[i]),
			.exe_target(exe_target[i]), .exe_cnt(exe_cnt[i])
		);
	end

	bht_resolve u_resolve (
		.CLK, .nrst, .en, .stall,
		.exe_pc, .exe_op, .exe_z, .exe_less,
		.if_hit, .if_target, .if_cnt, .exe_hit, .exe_target, .exe_cnt, .jump_alloc,
		.if_prediction, .if_pbt, .exe_correction, .exe_pbt, .exe_cni,
		.upd_we, .upd_set, .upd_cnt, .flush
	);

endmodule

/* test/tb_branch_predictor.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module tb_branch_predictor;
	import bp_isa_pkg::*;
	import bp_table_pkg::*;

	// reset and all tests together stay below this bound
	localparam int TEST_CYCLES    = 500;
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

	logic                CLK;
	logic                nrst;
	logic                en;
	logic                stall;
	logic                isr_running;
	logic [`BP_PC_W-1:0] if_pc;
	logic [`BP_PC_W-1:0] id_pc;
	logic [`BP_PC_W-1:0] id_target;
	logic                id_is_jump;
	logic                id_is_branch;
	logic [`BP_PC_W-1:0] exe_pc;
	branch_op_e          exe_op;
	logic                exe_z;
	logic                exe_less;
	logic                if_prediction;
	logic [`BP_PC_W-1:0] if_pbt;
	pc_fix_e             exe_correction;
	logic [`BP_PC_W-1:0] exe_pbt;
	logic [`BP_PC_W-1:0] exe_cni;
	logic                flush;
	logic                id_jump_in_bht;

	// reference model of table, fifo pointers and delayed flush
	logic                 m_valid  [`BP_SETS][`BP_WAYS];
	logic [`BP_TAG_W-1:0] m_tag    [`BP_SETS][`BP_WAYS];
	logic [`BP_PC_W-1:0]  m_target [`BP_SETS][`BP_WAYS];
	logic [`BP_CNT_W-1:0] m_cnt    [`BP_SETS][`BP_WAYS];
	logic [`BP_WAY_W-1:0] m_ptr    [`BP_SETS];
	logic                 m_flush_q;

	string               test_name;
	int                  cycle_count = 0;
	int                  errors = 0;
	// qualifiers used by every driven cycle
	logic                cycle_en;
	logic                cycle_stall;
	// branch shared by the allocation, resolution and stall tests
	logic [`BP_PC_W-1:0] br_pc;
	logic [`BP_PC_W-1:0] br_target;

	branch_predictor u_branch_predictor (
		.CLK, .nrst, .en, .stall, .isr_running, .if_pc,
		.id_pc, .id_target, .id_is_jump, .id_is_branch,
		.exe_pc, .exe_op, .exe_z, .exe_less,
		.if_prediction, .if_pbt, .exe_correction, .exe_pbt, .exe_cni,
		.flush, .id_jump_in_bht
	);

	always #2 CLK = ~CLK;

	// run limit
	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("Test FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// way holding pc in the given mode, -1 on a miss
	function automatic int lookup_way(input logic [`BP_PC_W-1:0] pc, input logic isr);
		int way;
		way = -1;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (m_valid[pc[`BP_SET_W-1:0]][w] &&
				m_tag[pc[`BP_SET_W-1:0]][w] == {isr, pc[`BP_PC_W-1:`BP_SET_W]}) begin
				way = w;
			end
		end
		return way;
	endfunction

	// branch outcome straight from the instruction semantics
	function automatic logic expect_taken(input branch_op_e op, input logic z,
		input logic less);
		case (op)
			BR_BEQ, BR_BEQZ: return z;
			BR_BNE, BR_BNEZ: return !z;
			BR_BLT, BR_BLTU: return less;
			BR_BGE, BR_BGEU: return !less;
			default:         return 1'b0;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		value_check: assert (exp_val === act_val) else begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_val,
				act_val);
			$display("Test FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// compare every output at mid cycle, then advance the model past the next edge
	task automatic check_cycle();
		int                   fw;
		int                   iw;
		int                   ew;
		logic [`BP_SET_W-1:0] fs;
		logic [`BP_SET_W-1:0] is;
		logic [`BP_SET_W-1:0] es;
		logic [`BP_CNT_W-1:0] cur_cnt;
		logic [`BP_CNT_W-1:0] new_cnt;
		logic [`BP_PC_W-1:0]  base;
		logic                 taken;
		logic                 mis;
		pc_fix_e              exp_fix;
		@(negedge CLK);
		fs = if_pc[`BP_SET_W-1:0];
		is = id_pc[`BP_SET_W-1:0];
		es = exe_pc[`BP_SET_W-1:0];
		fw = lookup_way(if_pc, isr_running);
		iw = lookup_way(id_pc, isr_running);
		ew = lookup_way(exe_pc, isr_running);
		cur_cnt = (ew >= 0) ? m_cnt[es][ew] : 2'd0;
		taken = expect_taken(exe_op, exe_z, exe_less);
		mis = (exe_op != BR_NONE) && (cur_cnt[1] != taken);
		exp_fix = !mis ? FIX_NONE : (taken ? FIX_PBT : FIX_CNI);
		// a miss reads as a zero tag
		base = (ew >= 0) ? exe_pc : {{(`BP_PC_W-`BP_SET_W){1'b0}}, es};
		base = base + (((exe_op == BR_BEQZ) || (exe_op == BR_BNEZ)) ? 11'd1 : 11'd2);
		check_value("if_prediction", (fw >= 0) ? m_cnt[fs][fw][1] : 1'b0, if_prediction);
		check_value("if_pbt", (fw >= 0) ? m_target[fs][fw] : '0, if_pbt);
		check_value("id_jump_in_bht", id_is_jump && (iw >= 0), id_jump_in_bht);
		check_value("exe_correction", exp_fix, exe_correction);
		check_value("exe_pbt", (ew >= 0) ? m_target[es][ew] : '0, exe_pbt);
		check_value("exe_cni", base, exe_cni);
		check_value("flush", m_flush_q || mis, flush);
		if (en && !stall) begin
			new_cnt = cur_cnt;
			if (taken && cur_cnt != 2'd3) begin
				new_cnt = cur_cnt + 2'd1;
			end else if (!taken && cur_cnt != 2'd0) begin
				new_cnt = cur_cnt - 2'd1;
			end
			if (exe_op != BR_NONE && ew >= 0) begin
				m_cnt[es][ew] = new_cnt;
			end
			// allocation lands after the update so it wins a same-way collision
			if ((id_is_branch || id_is_jump) && iw < 0) begin
				m_valid[is][m_ptr[is]]  = 1'b1;
				m_tag[is][m_ptr[is]]    = {isr_running, id_pc[`BP_PC_W-1:`BP_SET_W]};
				m_target[is][m_ptr[is]] = id_target;
				m_cnt[is][m_ptr[is]]    = id_is_jump ? 2'd3 : 2'd1;
				m_ptr[is]               = m_ptr[is] + 1'b1;
			end
			m_flush_q = m_flush_q ? 1'b0 : (mis || (id_is_jump && iw < 0));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// every cycle starts from idle inputs on the rising edge
	task automatic start_cycle();
		@(posedge CLK);
		en           <= cycle_en;
		stall        <= cycle_stall;
		isr_running  <= 1'b0;
		if_pc        <= '0;
		id_pc        <= '0;
		id_target    <= '0;
		id_is_jump   <= 1'b0;
		id_is_branch <= 1'b0;
		exe_pc       <= '0;
		exe_op       <= BR_NONE;
		exe_z        <= 1'b0;
		exe_less     <= 1'b0;
	endtask

	task automatic idle_cycle();
		start_cycle();
		check_cycle();
	endtask

	task automatic fetch_at(input logic [`BP_PC_W-1:0] pc, input logic isr);
		start_cycle();
		if_pc       <= pc;
		isr_running <= isr;
		check_cycle();
	endtask

	task automatic decode_at(input logic [`BP_PC_W-1:0] pc,
		input logic [`BP_PC_W-1:0] target, input logic jump);
		start_cycle();
		id_pc        <= pc;
		id_target    <= target;
		id_is_jump   <= jump;
		id_is_branch <= !jump;
		check_cycle();
	endtask

	task automatic execute_at(input logic [`BP_PC_W-1:0] pc, input branch_op_e op,
		input logic z);
		start_cycle();
		exe_pc <= pc;
		exe_op <= op;
		exe_z  <= z;
		check_cycle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	// empty table predicts nothing anywhere
	task automatic test_reset_lookup();
		test_name = "reset_lookup";
		for (int i = 0; i < 64; i++) begin
			start_cycle();
			if_pc       <= `BP_PC_W'($urandom);
			exe_pc      <= `BP_PC_W'($urandom);
			isr_running <= 1'($urandom);
			check_cycle();
			check_value("if_prediction", 0, if_prediction);
			check_value("if_pbt", 0, if_pbt);
			check_value("flush", 0, flush);
		end
	endtask

	task automatic test_alloc_and_jump();
		logic [`BP_PC_W-1:0] pcj;
		logic [`BP_PC_W-1:0] tj;
		test_name = "alloc_and_jump";
		br_pc     = {7'($urandom), 4'd3};
		br_target = `BP_PC_W'($urandom);
		pcj       = {7'($urandom), 4'd9};
		tj        = `BP_PC_W'($urandom);
		decode_at(br_pc, br_target, 1'b0);
		fetch_at(br_pc, 1'b0);
		check_value("if_prediction", 0, if_prediction);
		check_value("if_pbt", br_target, if_pbt);
		// new jump flushes exactly one cycle later
		decode_at(pcj, tj, 1'b1);
		check_value("flush", 0, flush);
		fetch_at(pcj, 1'b0);
		check_value("flush", 1, flush);
		check_value("if_prediction", 1, if_prediction);
		check_value("if_pbt", tj, if_pbt);
		idle_cycle();
		check_value("flush", 0, flush);
		// known jump is reported and does not flush
		decode_at(pcj, tj, 1'b1);
		check_value("id_jump_in_bht", 1, id_jump_in_bht);
		idle_cycle();
		check_value("flush", 0, flush);
	endtask

	task automatic test_resolve();
		logic [`BP_PC_W-1:0] pcc;
		test_name = "resolve";
		execute_at(br_pc, BR_BEQ, 1'b1);
		check_value("exe_correction", FIX_PBT, exe_correction);
		check_value("exe_pbt", br_target, exe_pbt);
		check_value("flush", 1, flush);
		fetch_at(br_pc, 1'b0);
		check_value("flush", 1, flush);
		check_value("if_prediction", 1, if_prediction);
		idle_cycle();
		check_value("flush", 0, flush);
		execute_at(br_pc, BR_BNE, 1'b1);
		check_value("exe_correction", FIX_CNI, exe_correction);
		check_value("exe_cni", br_pc + 11'd2, exe_cni);
		idle_cycle();
		fetch_at(br_pc, 1'b0);
		check_value("if_prediction", 0, if_prediction);
		// compressed branch steps one halfword
		pcc = {7'($urandom), 4'd6};
		decode_at(pcc, `BP_PC_W'($urandom), 1'b0);
		execute_at(pcc, BR_BEQZ, 1'b1);
		check_value("exe_correction", FIX_PBT, exe_correction);
		idle_cycle();
		execute_at(pcc, BR_BNEZ, 1'b1);
		check_value("exe_correction", FIX_CNI, exe_correction);
		check_value("exe_cni", pcc + 11'd1, exe_cni);
		idle_cycle();
		idle_cycle();
	endtask

	// five jumps into set 12, the oldest is evicted
	task automatic test_fifo_evict();
		logic [6:0]          base;
		logic [`BP_PC_W-1:0] pcs [5];
		test_name = "fifo_evict";
		base = 7'($urandom);
		for (int k = 0; k < 5; k++) begin
			pcs[k] = {7'(base + k * 17), 4'd12};
			decode_at(pcs[k], `BP_PC_W'($urandom), 1'b1);
		end
		idle_cycle();
		for (int k = 0; k < 5; k++) begin
			fetch_at(pcs[k], 1'b0);
			check_value("if_prediction", (k == 0) ? 0 : 1, if_prediction);
		end
	endtask

	task automatic test_isr_mode();
		logic [`BP_PC_W-1:0] pci;
		test_name = "isr_mode";
		pci = {7'($urandom), 4'd14};
		decode_at(pci, `BP_PC_W'($urandom), 1'b1);
		fetch_at(pci, 1'b1);
		check_value("if_prediction", 0, if_prediction);
		fetch_at(pci, 1'b0);
		check_value("if_prediction", 1, if_prediction);
	endtask

	// held pipeline, first with stall then with en low
	task automatic test_hold();
		logic [`BP_PC_W-1:0] pch;
		test_name = "hold";
		pch = {7'($urandom), 4'd1};
		for (int pass = 0; pass < 2; pass++) begin
			cycle_en    = (pass == 1) ? 1'b0 : 1'b1;
			cycle_stall = (pass == 0) ? 1'b1 : 1'b0;
			decode_at(pch, `BP_PC_W'($urandom), 1'b1);
			execute_at(br_pc, BR_BEQ, 1'b1);
			check_value("exe_correction", FIX_PBT, exe_correction);
			cycle_en    = 1'b1;
			cycle_stall = 1'b0;
			fetch_at(pch, 1'b0);
			check_value("if_prediction", 0, if_prediction);
			check_value("flush", 0, flush);
			fetch_at(br_pc, 1'b0);
			check_value("if_prediction", 0, if_prediction);
		end
	endtask

	initial begin
		void'($urandom(33854));
		CLK          = 1'b0;
		nrst         = 1'b0;
		en           = 1'b0;
		stall        = 1'b0;
		isr_running  = 1'b0;
		if_pc        = '0;
		id_pc        = '0;
		id_target    = '0;
		id_is_jump   = 1'b0;
		id_is_branch = 1'b0;
		exe_pc       = '0;
		exe_op       = BR_NONE;
		exe_z        = 1'b0;
		exe_less     = 1'b0;
		cycle_en     = 1'b1;
		cycle_stall  = 1'b0;
		// model starts from the reset state
		for (int s = 0; s < `BP_SETS; s++) begin
			m_ptr[s] = '0;
			for (int w = 0; w < `BP_WAYS; w++) begin
				m_valid[s][w] = 1'b0;
			end
		end
		m_flush_q = 1'b0;
		repeat (16) @(posedge CLK);
		nrst <= 1'b1;
		test_reset_lookup();
		test_alloc_and_jump();
		test_resolve();
		test_fifo_evict();
		test_isr_mode();
		test_hold();
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+source
source/bp_isa_pkg.sv
source/bp_table_pkg.sv
source/bht_way.sv
source/bht_alloc_ctrl.sv
source/bht_resolve.sv
source/branch_predictor.sv
test/tb_branch_predictor.sv

/* Bender.yml */
package:
  name: branch_predictor

sources:
  - include_dirs:
      - source
    files:
      - source/bp_isa_pkg.sv
      - source/bp_table_pkg.sv
      - source/bht_way.sv
      - source/bht_alloc_ctrl.sv
      - source/bht_resolve.sv
      - source/branch_predictor.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_branch_predictor.sv
